// File: src.f
src/ram_pkg.sv
src/stream_pkg.sv
src/sync_ram_sdp.sv
src/byte_bank.sv
src/word_packer.sv
src/width_doubler_top.sv
test/tb_width_doubler.sv

// File: Makefile
VERILATOR = verilator
TOP       = tb_width_doubler
FILELIST  = src.f
VFLAGS    = --binary --timing --assert --top-module $(TOP)
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = TB PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, search the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: test/tb_width_doubler.sv
`timescale 1ns/1ps

module tb_width_doubler;

  localparam int TOTAL_BYTES     = 2 + 64 + 16 + 40 + 2; // bytes sent over all tests
  localparam int WATCHDOG_CYCLES = TOTAL_BYTES * 4 + 2000;
  localparam int FILL_PAIRS      = ram_pkg::BANK_DEPTH + 4;

  logic                   clk;
  logic                   rst_n;
  stream_pkg::byte_beat_t in_beat;
  logic                   in_credit;
  stream_pkg::word_beat_t out_beat;
  logic                   out_credit;

  stream_pkg::word_t got_words[$];
  stream_pkg::word_t exp_words[$];

  string cur_test;
  int    error_count;
  int    test_count;
  int    failed_tests;
  int    test_errors_start;
  int    prod_credit;     // pair credits held upstream
  int    byte_parity;     // index parity of the next byte
  int    in_credit_count;
  int    word_count;
  int    pending_returns; // out_credit pulses still to drive
  int    held_credits;    // words taken but not credited back
  bit    auto_return;

  width_doubler_top UUT (
    .clk        (clk),
    .rst_n      (rst_n),
    .in_beat    (in_beat),
    .in_credit  (in_credit),
    .out_beat   (out_beat),
    .out_credit (out_credit)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic sample_outputs();
    if (rst_n) begin
      if (out_beat.valid) begin
        got_words.push_back(out_beat.data);
        word_count++;
        if (auto_return) begin
          pending_returns++;
        end else begin
          held_credits++;
        end
      end
      if (in_credit) begin
        in_credit_count++;
        prod_credit++;
      end
      if (in_credit !== out_beat.valid) begin
        $display("CHECK FAILED %s: in_credit expected %0b actual %0b",
                 cur_test, out_beat.valid, in_credit);
        error_count++;
      end
    end
  endtask

  // sample mid cycle, then drive just after the rising edge
  task automatic tick(input logic valid, input stream_pkg::byte_t data);
    @(negedge clk);
    sample_outputs();
    @(posedge clk);
    #1;
    in_beat.valid = valid;
    in_beat.data  = data;
    if (pending_returns > 0) begin
      out_credit = 1'b1;
      pending_returns--;
    end else begin
      out_credit = 1'b0;
    end
  endtask

  task automatic idle(input int cycles);
    repeat (cycles) tick(1'b0, '0);
  endtask

  task automatic send_byte(input stream_pkg::byte_t data);
    int waited;
    waited = 0;
    while (byte_parity == 0 && prod_credit == 0 && waited < 200) begin
      tick(1'b0, '0);
      waited++;
    end
    if (byte_parity == 0 && prod_credit == 0) begin
      $display("%s: producer never got a pair credit back", cur_test);
      error_count++;
    end
    if (byte_parity == 0) begin
      prod_credit--; // even byte opens a pair
    end
    tick(1'b1, data);
    byte_parity ^= 1;
  endtask

  task automatic send_pair(input stream_pkg::byte_t even, input stream_pkg::byte_t odd);
    send_byte(even);
    send_byte(odd);
    exp_words.push_back({odd, even});
  endtask

  task automatic wait_words(input int count, input int limit);
    int waited;
    waited = 0;
    while (got_words.size() < count && waited < limit) begin
      tick(1'b0, '0);
      waited++;
    end
    if (got_words.size() < count) begin
      $display("%s: only %0d of %0d words arrived within %0d cycles",
               cur_test, got_words.size(), count, limit);
      error_count++;
    end
  endtask

  task automatic check_int(input string what, input int expected, input int actual);
    if (actual != expected) begin
      $display("CHECK FAILED %s: %s expected %0d actual %0d", cur_test, what, expected, actual);
      error_count++;
    end
  endtask

  task automatic compare_words();
    check_int("word count", exp_words.size(), got_words.size());
    foreach (exp_words[i]) begin
      if (i < got_words.size() && got_words[i] !== exp_words[i]) begin
        $display("CHECK FAILED %s: word %0d expected %h actual %h",
                 cur_test, i, exp_words[i], got_words[i]);
        error_count++;
      end
    end
  endtask

  task automatic return_held(input int count);
    pending_returns += count;
    held_credits    -= count;
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    got_words.delete();
    exp_words.delete();
    test_errors_start = error_count;
    test_count++;
  endtask

  task automatic end_test();
    if (error_count == test_errors_start) begin
      $display("%-16s ok", cur_test);
    end else begin
      failed_tests++;
      $display("%-16s failed with %0d errors", cur_test, error_count - test_errors_start);
    end
  endtask

  task automatic test_reset();
    start_test("reset");
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #1;
      if (out_beat.valid !== 1'b0 || in_credit !== 1'b0) begin
        $display("CHECK FAILED %s: valid,in_credit expected 0,0 actual %b,%b",
                 cur_test, out_beat.valid, in_credit);
        error_count++;
      end
    end
    rst_n = 1'b1;
    idle(2);
    check_int("words after reset", 0, got_words.size());
    check_int("in_credit pulses after reset", 0, in_credit_count);
    end_test();
  endtask

  task automatic test_single_pair();
    start_test("single_pair");
    send_pair(8'h11, 8'h22);
    wait_words(1, 20);
    idle(5);
    compare_words();
    end_test();
  endtask

  task automatic test_ordered_stream();
    start_test("ordered_stream");
    for (int i = 0; i < 32; i++) begin
      send_pair(stream_pkg::byte_t'($urandom), stream_pkg::byte_t'($urandom));
    end
    wait_words(32, 200);
    idle(5);
    compare_words();
    end_test();
  endtask

  task automatic test_back_pressure();
    start_test("back_pressure");
    auto_return = 1'b0;
    for (int i = 0; i < 8; i++) begin
      send_pair(stream_pkg::byte_t'(8'h40 + 2 * i), stream_pkg::byte_t'(8'h41 + 2 * i));
    end
    wait_words(stream_pkg::OUT_CREDIT_INIT, 50);
    idle(20); // output must stay quiet here
    check_int("words without credit", stream_pkg::OUT_CREDIT_INIT, got_words.size());
    for (int i = 1; i <= 4; i++) begin
      return_held(1);
      wait_words(stream_pkg::OUT_CREDIT_INIT + i, 20);
      idle(2);
      check_int("words per returned credit", stream_pkg::OUT_CREDIT_INIT + i, got_words.size());
    end
    compare_words();
    return_held(held_credits);
    auto_return = 1'b1;
    idle(6);
    end_test();
  endtask

  task automatic test_credit_loop();
    int base_pulses;
    int base_words;
    start_test("credit_loop");
    base_pulses = in_credit_count;
    base_words  = word_count;
    auto_return = 1'b0;
    for (int i = 0; i < FILL_PAIRS; i++) begin
      send_pair(stream_pkg::byte_t'($urandom), stream_pkg::byte_t'($urandom));
    end
    idle(10);
    check_int("words while memory full", stream_pkg::OUT_CREDIT_INIT, got_words.size());
    check_int("producer credits while full", 0, prod_credit);
    check_int("in_credit pulses", word_count - base_words, in_credit_count - base_pulses);
    return_held(held_credits);
    auto_return = 1'b1;
    wait_words(FILL_PAIRS, 200);
    idle(10);
    check_int("in_credit pulses", word_count - base_words, in_credit_count - base_pulses);
    check_int("producer credits after drain", ram_pkg::BANK_DEPTH, prod_credit);
    compare_words();
    end_test();
  endtask

  task automatic test_unpaired();
    start_test("unpaired_byte");
    send_byte(8'h5a);
    idle(20);
    check_int("words from a lone byte", 0, got_words.size());
    send_byte(8'ha5);
    exp_words.push_back({8'ha5, 8'h5a});
    wait_words(1, 20);
    idle(5);
    compare_words();
    check_int("producer credits", ram_pkg::BANK_DEPTH, prod_credit);
    end_test();
  endtask

  initial begin
    rst_n           = 1'b0;
    in_beat         = '0;
    out_credit      = 1'b0;
    error_count     = 0;
    test_count      = 0;
    failed_tests    = 0;
    prod_credit     = ram_pkg::BANK_DEPTH;
    byte_parity     = 0;
    in_credit_count = 0;
    word_count      = 0;
    pending_returns = 0;
    held_credits    = 0;
    auto_return     = 1'b1;
    void'($urandom(46019));
    test_reset();
    test_single_pair();
    test_ordered_stream();
    test_back_pressure();
    test_credit_loop();
    test_unpaired();
    $display("tests run %0d, tests failed %0d, checks failed %0d",
             test_count, failed_tests, error_count);
    if (error_count == 0) begin
      $display("TB PASSED");
    end else begin
      $display("TB FAILED");
    end
    $finish;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog expired after %0d cycles, the tests did not finish", WATCHDOG_CYCLES);
    $display("TB FAILED");
    $finish;
  end

endmodule

// File: src/width_doubler_top.sv
`timescale 1ns/1ps

module width_doubler_top (
  input  logic                   clk,
  input  logic                   rst_n,
  input  stream_pkg::byte_beat_t in_beat,
  output logic                   in_credit,
  output stream_pkg::word_beat_t out_beat,
  input  logic                   out_credit
);

  logic              even_empty;
  logic              odd_empty;
  stream_pkg::byte_t even_data;
  stream_pkg::byte_t odd_data;
  logic              pop; // shared by both banks

  byte_bank #(
    .LANE (0)
  ) even_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_beat (in_beat),
    .pop     (pop),
    .empty   (even_empty),
    .rd_data (even_data)
  );

  byte_bank #(
    .LANE (1)
  ) odd_bank (
    .clk     (clk),
    .rst_n   (rst_n),
    .in_beat (in_beat),
    .pop     (pop),
    .empty   (odd_empty),
    .rd_data (odd_data)
  );

  word_packer packer (
    .clk        (clk),
    .rst_n      (rst_n),
    .even_empty (even_empty),
    .odd_empty  (odd_empty),
    .even_data  (even_data),
    .odd_data   (odd_data),
    .pop        (pop),
    .out_credit (out_credit),
    .out_beat   (out_beat),
    .in_credit  (in_credit)
  );

endmodule

// File: src/word_packer.sv
`timescale 1ns/1ps

module word_packer (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   even_empty,
  input  logic                   odd_empty,
  input  stream_pkg::byte_t      even_data,
  input  stream_pkg::byte_t      odd_data,
  output logic                   pop,
  input  logic                   out_credit,
  output stream_pkg::word_beat_t out_beat,
  output logic                   in_credit
);

  stream_pkg::credit_t credit; // words the consumer can still take
  logic                has_credit;
  logic                out_valid;

  assign has_credit = (credit != '0);

  // one pop covers one byte from each bank
  assign pop = !even_empty && !odd_empty && has_credit;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      credit <= stream_pkg::credit_t'(stream_pkg::OUT_CREDIT_INIT);
    end else begin
      case ({pop, out_credit})
        2'b10:   credit <= credit - stream_pkg::credit_t'(1);
        2'b01:   credit <= credit + stream_pkg::credit_t'(1);
        default: credit <= credit; // spend and return cancel out
      endcase
    end
  end

  // RAM read data lands one cycle after the pop, valid follows it
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      out_valid <= 1'b0;
      in_credit <= 1'b0;
    end else begin
      out_valid <= pop;
      in_credit <= pop; // freed pair slot goes back upstream
    end
  end

  always_comb begin
    out_beat.valid = out_valid;
    out_beat.data  = {odd_data, even_data}; // odd byte high
  end

  // consumer must not hand back more credits than it was given
  a_credit_bound: assert property (
    @(posedge clk) disable iff (!rst_n)
    credit <= stream_pkg::credit_t'(stream_pkg::OUT_CREDIT_INIT)
  ) else $error("word_packer credit count %0d above limit", credit);

endmodule

// File: src/byte_bank.sv
`timescale 1ns/1ps

module byte_bank #(
  parameter int LANE = 0
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  stream_pkg::byte_beat_t in_beat,
  input  logic                   pop,
  output logic                   empty,
  output stream_pkg::byte_t      rd_data
);

  // phase value on which this bank takes the byte
  localparam logic LANE_PHASE = (LANE != 0);

  if (LANE < 0 || LANE > 1) begin : g_lane_check
    $error("byte_bank LANE must be 0 or 1");
  end

  logic             phase; // parity of the next input byte
  logic             wr_en;
  ram_pkg::addr_t   wr_ptr;
  ram_pkg::addr_t   rd_ptr;
  ram_pkg::count_t  count;

  assign wr_en = in_beat.valid && (phase == LANE_PHASE);
  assign empty = (count == '0);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= 1'b0;
    end else if (in_beat.valid) begin
      phase <= ~phase;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_en) begin
        wr_ptr <= wr_ptr + ram_pkg::addr_t'(1); // wraps at depth
      end
      if (pop) begin
        rd_ptr <= rd_ptr + ram_pkg::addr_t'(1);
      end
      case ({wr_en, pop})
        2'b10:   count <= count + ram_pkg::count_t'(1);
        2'b01:   count <= count - ram_pkg::count_t'(1);
        default: count <= count; // idle or write and pop together
      endcase
    end
  end

  // read address follows rd_ptr, so a pop at edge P latches the head entry
  sync_ram_sdp #(
    .DATA_WIDTH    (stream_pkg::BYTE_W),
    .ADDRESS_WIDTH (ram_pkg::ADDR_W)
  ) ram (
    .clk          (clk),
    .write_enable (wr_en),
    .address_w    (wr_ptr),
    .address_r    (rd_ptr),
    .data_in      (in_beat.data),
    .data_out     (rd_data)
  );

  // upstream credit loop must keep the bank from overflowing
  a_no_overflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    wr_en |-> (count != ram_pkg::count_t'(ram_pkg::BANK_DEPTH)) || pop
  ) else $error("byte_bank lane %0d write while full", LANE);

  // packer only pops when both banks hold data
  a_no_underflow: assert property (
    @(posedge clk) disable iff (!rst_n)
    pop |-> !empty
  ) else $error("byte_bank lane %0d pop while empty", LANE);

endmodule

// File: src/sync_ram_sdp.sv
`timescale 1ns/1ps

module sync_ram_sdp #(
  parameter int DATA_WIDTH    = 8,
  parameter int ADDRESS_WIDTH = 10
) (
  input  logic                     clk,
  input  logic                     write_enable,
  input  logic [ADDRESS_WIDTH-1:0] address_w,
  input  logic [ADDRESS_WIDTH-1:0] address_r,
  input  logic [DATA_WIDTH-1:0]    data_in,
  output logic [DATA_WIDTH-1:0]    data_out
);

  localparam int DEPTH = 2 ** ADDRESS_WIDTH;

  logic [DATA_WIDTH-1:0] memory [0:DEPTH-1];
  logic [DATA_WIDTH-1:0] data_out_r;

  always_ff @(posedge clk) begin
    if (write_enable) begin
      memory[address_w] <= data_in;
    end
    data_out_r <= memory[address_r]; // read first, new data seen next cycle
  end

  assign data_out = data_out_r;

endmodule

// File: src/stream_pkg.sv
package stream_pkg;

  localparam int BYTE_W   = 8;
  localparam int WORD_W   = 2 * BYTE_W;
  localparam int CREDIT_W = 3;

  localparam int OUT_CREDIT_INIT = 4; // words the consumer can take after reset

  typedef logic [BYTE_W-1:0]   byte_t;
  typedef logic [WORD_W-1:0]   word_t; // even byte in 7..0
  typedef logic [CREDIT_W-1:0] credit_t;

  // input stream, one byte per valid cycle
  typedef struct packed {
    logic  valid;
    byte_t data;
  } byte_beat_t;

  // output stream, one packed pair per valid cycle
  typedef struct packed {
    logic  valid;
    word_t data;
  } word_beat_t;

endpackage

// File: src/ram_pkg.sv
package ram_pkg;

  localparam int ADDR_W     = 4;
  localparam int BANK_DEPTH = 2 ** ADDR_W; // byte pairs per bank

  // bank address
  typedef logic [ADDR_W-1:0] addr_t;

  // fill count, one bit wider so full is 16
  typedef logic [ADDR_W:0] count_t;

endpackage
